// File: exec_unit.f
+incdir+source
source/rv_format_pkg.sv
source/exec_op_pkg.sv
source/imm_decoder.sv
source/int_alu.sv
source/branch_unit.sv
source/serial_divider.sv
source/exec_unit.sv
tb/tb_exec_unit.sv

// File: source/branch_unit.sv
`timescale 1ns/10ps
`include "exec_config.svh"

module branch_unit (
  input  exec_op_pkg::exec_op_e      i_op,
  input  logic [`XLEN-1:0]           i_a,
  input  logic [`XLEN-1:0]           i_b,
  input  logic [`XLEN-1:0]           i_pc,
  input  rv_format_pkg::imm_bundle_t i_imm,
  output logic                       o_jump,
  output logic [`XLEN-1:0]           o_jump_address
);
  import exec_op_pkg::*;
  import rv_format_pkg::*;

  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq   = i_a == i_b;
  assign lt_s = $signed(i_a) < $signed(i_b);
  assign lt_u = i_a < i_b;

  always_comb begin
    o_jump         = 1'b0;
    o_jump_address = i_pc + i_imm.imm_b;
    case (i_op)
      OP_BEQ:  o_jump = eq;
      OP_BNE:  o_jump = !eq;
      OP_BLT:  o_jump = lt_s;
      OP_BGE:  o_jump = !lt_s;
      OP_BLTU: o_jump = lt_u;
      OP_BGEU: o_jump = !lt_u;
      OP_JAL: begin
        o_jump         = 1'b1;
        o_jump_address = i_pc + i_imm.imm_j;
      end
      OP_JALR: begin
        o_jump         = 1'b1;
        o_jump_address = i_a + i_imm.imm_i;  // Register relative
      end
      default: ;
    endcase
  end

endmodule

// File: source/exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Data path width
`define XLEN 32
`define OP_W 6

// One quotient bit per cycle
`define DIV_STEPS 32
`define PC_STEP 4

`endif

// File: source/exec_op_pkg.sv
`include "exec_config.svh"

package exec_op_pkg;

  typedef enum logic [`OP_W-1:0] {
    OP_ADD    = 0,
    OP_SUB    = 1,
    OP_SLL    = 2,
    OP_SLT    = 3,
    OP_SLTU   = 4,
    OP_XOR    = 5,
    OP_SRL    = 6,
    OP_SRA    = 7,
    OP_OR     = 8,
    OP_AND    = 9,
    OP_MUL    = 10,
    OP_MULH   = 11,
    OP_MULHSU = 12,
    OP_MULHU  = 13,
    OP_DIV    = 14,
    OP_DIVU   = 15,
    OP_REM    = 16,
    OP_REMU   = 17,
    OP_ADDI   = 18,
    OP_SLTI   = 19,
    OP_SLTIU  = 20,
    OP_XORI   = 21,
    OP_ORI    = 22,
    OP_ANDI   = 23,
    OP_SLLI   = 24,
    OP_SRLI   = 25,
    OP_SRAI   = 26,
    OP_BEQ    = 35,  // 27 to 34 unused
    OP_BNE    = 36,
    OP_BLT    = 37,
    OP_BGE    = 38,
    OP_BLTU   = 39,
    OP_BGEU   = 40,
    OP_JAL    = 41,
    OP_JALR   = 42,
    OP_LUI    = 43,
    OP_AUIPC  = 44
  } exec_op_e;

  typedef struct packed {
    exec_op_e              op;
    logic [`XLEN-1:0]      a;
    logic [`XLEN-1:0]      b;
    rv_format_pkg::instr_u ir;
    logic [`XLEN-1:0]      pc;
  } exec_req_t;

  typedef struct packed {
    logic             load_regfile;
    logic [`XLEN-1:0] result;
    logic             jump;
    logic [`XLEN-1:0] jump_address;
  } exec_rsp_t;

  function automatic logic is_div_op(exec_op_e op);
    return op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  endfunction

endpackage

// File: source/exec_unit.sv
`timescale 1ns/10ps
`include "exec_config.svh"

module exec_unit (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_execute,
  input  exec_op_pkg::exec_req_t i_req,
  output exec_op_pkg::exec_rsp_t o_rsp
);
  import exec_op_pkg::*;
  import rv_format_pkg::*;

  imm_bundle_t      imm;
  logic [`XLEN-1:0] alu_result;
  logic             alu_load;
  logic             br_jump;
  logic [`XLEN-1:0] br_addr;
  logic             div_op;
  logic             div_signed;
  logic             div_rem;
  logic             div_start;
  logic             div_busy;
  logic             div_done;
  logic [`XLEN-1:0] div_result;

  assign div_op     = is_div_op(i_req.op);
  assign div_signed = i_req.op inside {OP_DIV, OP_REM};
  assign div_rem    = i_req.op inside {OP_REM, OP_REMU};
  // Done cycle blocks a restart while execute is still high
  assign div_start  = i_execute & div_op & ~div_busy & ~div_done;

  imm_decoder u_imm (.i_ir(i_req.ir), .o_imm(imm));

  int_alu u_alu (
    .i_op(i_req.op), .i_a(i_req.a), .i_b(i_req.b), .i_pc(i_req.pc),
    .i_imm(imm), .o_result(alu_result), .o_load(alu_load)
  );

  branch_unit u_branch (
    .i_op(i_req.op), .i_a(i_req.a), .i_b(i_req.b), .i_pc(i_req.pc),
    .i_imm(imm), .o_jump(br_jump), .o_jump_address(br_addr)
  );

  serial_divider u_div (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(div_start),
    .i_signed(div_signed), .i_want_rem(div_rem),
    .i_dividend(i_req.a), .i_divisor(i_req.b),
    .o_busy(div_busy), .o_done(div_done), .o_result(div_result)
  );

  always_comb begin
    o_rsp.load_regfile = i_execute & (div_op ? div_done : alu_load);
    o_rsp.result       = div_op ? div_result : alu_result;
    o_rsp.jump         = i_execute & br_jump;
    o_rsp.jump_address = br_addr;
  end

endmodule

// File: source/imm_decoder.sv
`timescale 1ns/10ps
`include "exec_config.svh"

module imm_decoder (
  input  rv_format_pkg::instr_u      i_ir,
  output rv_format_pkg::imm_bundle_t o_imm
);
  import rv_format_pkg::*;

  logic sign;

  assign sign = i_ir.bj_view.sign;

  assign o_imm.imm_i = {{(`XLEN-12){sign}}, i_ir.i_view.imm};

  assign o_imm.imm_b = {{(`XLEN-12){sign}},
                        i_ir.bj_view.f7,
                        i_ir.bj_view.f30_25,
                        i_ir.bj_view.f11_8,
                        1'b0};

  // imm[20|10:1|11|19:12] order in the word
  assign o_imm.imm_j = {{(`XLEN-20){sign}},
                        i_ir.bj_view.f19_12,
                        i_ir.bj_view.f20,
                        i_ir.bj_view.f30_25,
                        i_ir.bj_view.f24_21,
                        1'b0};

  assign o_imm.imm_u = {i_ir.i_view.imm,
                        i_ir.i_view.rs1,
                        i_ir.i_view.funct3,
                        12'b0};

endmodule

// File: source/int_alu.sv
`timescale 1ns/10ps
`include "exec_config.svh"

module int_alu (
  input  exec_op_pkg::exec_op_e      i_op,
  input  logic [`XLEN-1:0]           i_a,
  input  logic [`XLEN-1:0]           i_b,
  input  logic [`XLEN-1:0]           i_pc,
  input  rv_format_pkg::imm_bundle_t i_imm,
  output logic [`XLEN-1:0]           o_result,
  output logic                       o_load
);
  import exec_op_pkg::*;
  import rv_format_pkg::*;

  localparam int SH_W = $clog2(`XLEN);

  logic [SH_W-1:0]      shamt_r;
  logic [SH_W-1:0]      shamt_i;
  logic                 lt_s_r;
  logic                 lt_u_r;
  logic                 lt_s_i;
  logic                 lt_u_i;
  logic [2*`XLEN-1:0]   prod_ss;
  logic [2*`XLEN-1:0]   prod_uu;
  logic [2*`XLEN+1:0]   prod_su;  // Extra sign bits for the mixed case

  assign shamt_r = i_b[SH_W-1:0];
  assign shamt_i = i_imm.imm_i[SH_W-1:0];

  assign lt_s_r = $signed(i_a) < $signed(i_b);
  assign lt_u_r = i_a < i_b;
  assign lt_s_i = $signed(i_a) < $signed(i_imm.imm_i);
  assign lt_u_i = i_a < i_imm.imm_i;  // Sign-extended imm compared unsigned

  assign prod_ss = $signed(i_a) * $signed(i_b);
  assign prod_uu = i_a * i_b;
  assign prod_su = $signed({i_a[`XLEN-1], i_a}) * $signed({1'b0, i_b});

  always_comb begin
    o_result = '0;
    o_load   = 1'b1;
    case (i_op)
      OP_ADD:    o_result = i_a + i_b;
      OP_SUB:    o_result = i_a - i_b;
      OP_SLL:    o_result = i_a << shamt_r;
      OP_SLT:    o_result = `XLEN'(lt_s_r);
      OP_SLTU:   o_result = `XLEN'(lt_u_r);
      OP_XOR:    o_result = i_a ^ i_b;
      OP_SRL:    o_result = i_a >> shamt_r;
      OP_SRA:    o_result = $signed(i_a) >>> shamt_r;
      OP_OR:     o_result = i_a | i_b;
      OP_AND:    o_result = i_a & i_b;
      OP_MUL:    o_result = prod_ss[`XLEN-1:0];
      OP_MULH:   o_result = prod_ss[2*`XLEN-1:`XLEN];
      OP_MULHSU: o_result = prod_su[2*`XLEN-1:`XLEN];
      OP_MULHU:  o_result = prod_uu[2*`XLEN-1:`XLEN];
      OP_ADDI:   o_result = i_a + i_imm.imm_i;
      OP_SLTI:   o_result = `XLEN'(lt_s_i);
      OP_SLTIU:  o_result = `XLEN'(lt_u_i);
      OP_XORI:   o_result = i_a ^ i_imm.imm_i;
      OP_ORI:    o_result = i_a | i_imm.imm_i;
      OP_ANDI:   o_result = i_a & i_imm.imm_i;
      OP_SLLI:   o_result = i_a << shamt_i;
      OP_SRLI:   o_result = i_a >> shamt_i;
      OP_SRAI:   o_result = $signed(i_a) >>> shamt_i;
      OP_JAL,
      OP_JALR:   o_result = i_pc + `XLEN'(`PC_STEP);  // Link address
      OP_LUI:    o_result = i_imm.imm_u;
      OP_AUIPC:  o_result = i_pc + i_imm.imm_u;
      default: begin  // Branches and divides
        o_result = '0;
        o_load   = 1'b0;
      end
    endcase
  end

endmodule

// File: source/rv_format_pkg.sv
`include "exec_config.svh"

package rv_format_pkg;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // B and J immediates are scattered over these groups
  typedef struct packed {
    logic       sign;     // Bit 31
    logic [5:0] f30_25;
    logic [3:0] f24_21;
    logic       f20;
    logic [7:0] f19_12;
    logic [3:0] f11_8;
    logic       f7;
    logic [6:0] opcode;
  } bj_fmt_t;

  typedef union packed {
    i_fmt_t  i_view;
    bj_fmt_t bj_view;
  } instr_u;

  typedef struct packed {
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm_u;
  } imm_bundle_t;

endpackage

// File: source/serial_divider.sv
`timescale 1ns/10ps
`include "exec_config.svh"

module serial_divider (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_start,
  input  logic             i_signed,
  input  logic             i_want_rem,
  input  logic [`XLEN-1:0] i_dividend,
  input  logic [`XLEN-1:0] i_divisor,
  output logic             o_busy,
  output logic             o_done,
  output logic [`XLEN-1:0] o_result
);

  localparam int CNT_W = $clog2(`DIV_STEPS);

  typedef enum logic [1:0] {
    S_IDLE,
    S_RUN,
    S_FIX
  } state_e;

  state_e           state;
  logic [CNT_W-1:0] step_cnt;
  logic             done;
  logic [`XLEN-1:0] quo;  // Dividend shifts out, quotient shifts in
  logic [`XLEN-1:0] rem;
  logic [`XLEN-1:0] dvs_mag;
  logic             neg_q;
  logic             neg_r;
  logic             rem_sel;
  logic             a_neg;
  logic             b_neg;
  logic [`XLEN-1:0] a_mag;
  logic [`XLEN-1:0] b_mag;
  logic [`XLEN:0]   rem_shift;
  logic [`XLEN:0]   rem_trial;
  logic             fits;

  assign a_neg = i_signed & i_dividend[`XLEN-1];
  assign b_neg = i_signed & i_divisor[`XLEN-1];
  assign a_mag = a_neg ? -i_dividend : i_dividend;
  assign b_mag = b_neg ? -i_divisor : i_divisor;

  assign rem_shift = {rem, quo[`XLEN-1]};
  assign rem_trial = rem_shift - {1'b0, dvs_mag};
  assign fits      = rem_shift >= {1'b0, dvs_mag};

  assign o_busy = state != S_IDLE;
  assign o_done = done;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state    <= S_IDLE;
      step_cnt <= '0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_start) begin
            state    <= S_RUN;
            step_cnt <= '0;
          end
        end
        S_RUN: begin
          step_cnt <= step_cnt + 1'b1;
          if (step_cnt == CNT_W'(`DIV_STEPS - 1)) state <= S_FIX;
        end
        S_FIX: begin
          state <= S_IDLE;
          done  <= 1'b1;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == S_IDLE && i_start) begin
      quo     <= a_mag;
      rem     <= '0;
      dvs_mag <= b_mag;
      // Zero divisor keeps the all-ones quotient unsigned
      neg_q   <= (a_neg ^ b_neg) & (|i_divisor);
      neg_r   <= a_neg;
      rem_sel <= i_want_rem;
    end else if (state == S_RUN) begin
      rem <= fits ? rem_trial[`XLEN-1:0] : rem_shift[`XLEN-1:0];
      quo <= {quo[`XLEN-2:0], fits};
    end else if (state == S_FIX) begin
      // Most-negative over minus one wraps back to itself
      if (rem_sel) o_result <= neg_r ? -rem : rem;
      else o_result <= neg_q ? -quo : quo;
    end
  end

endmodule

// File: tb/exec_patterns.txt
02 00000003 00000024 00000000 00000000 00000030 1 0 00000000
03 fffffffe 00000001 00000000 00000000 00000001 1 0 00000000
04 fffffffe 00000001 00000000 00000000 00000000 1 0 00000000
1a 80000000 00000000 02400013 00000000 f8000000 1 0 00000000
12 00000100 00000000 ff000013 00000000 000000f0 1 0 00000000
0a fffffffd 00000007 00000000 00000000 ffffffeb 1 0 00000000
0b 80000000 80000000 00000000 00000000 40000000 1 0 00000000
0c ffffffff ffffffff 00000000 00000000 ffffffff 1 0 00000000
0d ffffffff ffffffff 00000000 00000000 fffffffe 1 0 00000000
2b 00000000 00000000 12345037 00000000 12345000 1 0 00000000
2c 00000000 00000000 fffff017 00002004 00001004 1 0 00000000
23 00000005 00000005 00000863 00000100 00000000 0 1 00000110
23 00000005 00000006 fe000ce3 00000100 00000000 0 0 000000f8
24 00000005 00000006 fe000ce3 00000100 00000000 0 1 000000f8
24 00000005 00000005 00000863 00000100 00000000 0 0 00000110
25 ffffffff 00000001 00000863 00000100 00000000 0 1 00000110
25 00000001 ffffffff fe000ce3 00000100 00000000 0 0 000000f8
26 00000001 ffffffff fe000ce3 00000100 00000000 0 1 000000f8
26 ffffffff 00000001 00000863 00000100 00000000 0 0 00000110
27 00000001 ffffffff 00000863 00000100 00000000 0 1 00000110
27 ffffffff 00000001 fe000ce3 00000100 00000000 0 0 000000f8
28 ffffffff 00000001 fe000ce3 00000100 00000000 0 1 000000f8
28 00000001 ffffffff 00000863 00000100 00000000 0 0 00000110
29 00000000 00000000 0210106f 00000100 00000104 1 1 00001920
2a 00002000 00000000 ffc00067 00000200 00000204 1 1 00001ffc
0e ffffffec 00000003 00000000 00000000 fffffffa 1 0 00000000
10 00000014 fffffffd 00000000 00000000 00000002 1 0 00000000
0f ffffffec 00000003 00000000 00000000 5555554e 1 0 00000000
11 ffffffec 00000003 00000000 00000000 00000002 1 0 00000000
0e fffffff9 00000000 00000000 00000000 ffffffff 1 0 00000000
10 fffffff9 00000000 00000000 00000000 fffffff9 1 0 00000000
0e 80000000 ffffffff 00000000 00000000 80000000 1 0 00000000
10 80000000 ffffffff 00000000 00000000 00000000 1 0 00000000

// File: tb/tb_exec_unit.sv
`timescale 1ns/10ps

module tb_exec_unit;
  import exec_op_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        execute;
  exec_req_t   req;
  exec_rsp_t   rsp;
  integer      fd;
  integer      seed;
  integer      n_lines;
  logic [31:0] f_op;
  logic [31:0] f_a;
  logic [31:0] f_b;
  logic [31:0] f_ir;
  logic [31:0] f_pc;
  logic [31:0] f_res;
  logic [31:0] f_load;
  logic [31:0] f_jump;
  logic [31:0] f_addr;

  exec_unit dut0 (
    .i_clk(clk), .i_rst_n(rst_n), .i_execute(execute), .i_req(req), .o_rsp(rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  function automatic logic is_divide_code(logic [31:0] op);
    return op >= 14 && op <= 17;  // DIV, DIVU, REM, REMU
  endfunction

  function automatic logic is_branch_code(logic [31:0] op);
    return op >= 35 && op <= 42;  // Branches, JAL, JALR
  endfunction

  task automatic drive_request(input logic [31:0] op, input logic [31:0] a,
                               input logic [31:0] b, input logic [31:0] ir,
                               input logic [31:0] pc);
    @(posedge clk);
    #1;
    req.op  = exec_op_e'(op[5:0]);
    req.a   = a;
    req.b   = b;
    req.ir  = ir;
    req.pc  = pc;
    execute = 1'b1;
  endtask

  task automatic wait_divider_load();
    integer cycles;
    cycles = 0;
    @(negedge clk);
    while (!rsp.load_regfile) begin
      if (cycles == 100) begin
        $display("Timeout: the divider gave no load pulse within 100 cycles");
        $display("TESTS FAILED");
        $fatal(1, "divider timeout");
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  initial begin
    seed    = 55;
    n_lines = 0;
    rst_n   = 1'b0;
    execute = 1'b0;
    req     = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int k = 0; k <= 44; k++) begin  // Idle stage masks every op
      @(posedge clk);
      #1;
      req.op = exec_op_e'(k);
      @(negedge clk);
      check_value(rsp.load_regfile, 0, $sformatf("op %0d load while idle", k));
      check_value(rsp.jump, 0, $sformatf("op %0d jump while idle", k));
    end
    fd = $fopen("tb/exec_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file tb/exec_patterns.txt");
      $display("TESTS FAILED");
      $fatal(1, "missing pattern file");
    end
    while ($fscanf(fd, "%h %h %h %h %h %h %h %h %h", f_op, f_a, f_b, f_ir, f_pc,
                   f_res, f_load, f_jump, f_addr) == 9) begin
      n_lines++;
      drive_request(f_op, f_a, f_b, f_ir, f_pc);
      if (is_divide_code(f_op)) wait_divider_load();
      else @(negedge clk);
      check_value(rsp.load_regfile, f_load, $sformatf("op %0h load", f_op));
      check_value(rsp.jump, f_jump, $sformatf("op %0h jump", f_op));
      if (f_load[0]) check_value(rsp.result, f_res, $sformatf("op %0h result", f_op));
      if (is_branch_code(f_op))
        check_value(rsp.jump_address, f_addr, $sformatf("op %0h target", f_op));
      if (is_divide_code(f_op)) begin
        @(posedge clk);
        #1;
        check_value(rsp.load_regfile, 0, "load after divide pulse");  // Single pulse
        execute = 1'b0;
      end
    end
    $fclose(fd);
    if (n_lines == 0) begin
      $display("The pattern file tb/exec_patterns.txt held no readable record");
      $display("TESTS FAILED");
      $fatal(1, "empty pattern file");
    end
    for (int n = 0; n < 20; n++) begin  // ADD on even, SUB on odd
      f_a = $random(seed);
      f_b = $random(seed);
      drive_request(n % 2, f_a, f_b, 0, 0);
      @(negedge clk);
      check_value(rsp.result, (n % 2) ? f_a - f_b : f_a + f_b, "random add/sub result");
      check_value(rsp.load_regfile, 1, "random add/sub load");
      check_value(rsp.jump, 0, "random add/sub jump");
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule
